// ==== rtl/fc_svc_pkg.sv ====
/* Fuse and lifecycle service controller shared definitions.
   Holds the command codes, the width typedefs and the state encodings. */

`default_nettype none

package fc_svc_pkg;

  // --------------------------------------------------
  // Widths that carry a meaning
  // --------------------------------------------------
  typedef logic [7:0]  svc_cmd_t;
  typedef logic [10:0] clk_mhz_t;
  typedef logic [15:0] fuse_word_t;
  typedef logic        fault_kind_t;

  parameter fault_kind_t FAULT_CORRECTABLE   = 1'b0;
  parameter fault_kind_t FAULT_UNCORRECTABLE = 1'b1;

  // Frequency selected out of reset.
  parameter clk_mhz_t CLK_MHZ_RST = 11'd1000;

  // Length of the sub-block reset window in clock cycles.
  parameter int unsigned SUB_RST_CYCLES = 11;

  // --------------------------------------------------
  // Service command codes
  // --------------------------------------------------
  parameter svc_cmd_t CMD_FORCE_ZEROIZATION   = 8'h10;
  parameter svc_cmd_t CMD_RELEASE_ZEROIZATION = 8'h11;
  parameter svc_cmd_t CMD_TRIGGER_ESCALATION  = 8'h20;
  parameter svc_cmd_t CMD_RELEASE_ESCALATION  = 8'h21;
  parameter svc_cmd_t CMD_EXT_CLK_160         = 8'h30;
  parameter svc_cmd_t CMD_EXT_CLK_400         = 8'h31;
  parameter svc_cmd_t CMD_EXT_CLK_500         = 8'h32;
  parameter svc_cmd_t CMD_EXT_CLK_1000        = 8'h33;
  parameter svc_cmd_t CMD_SUB_RESET           = 8'h40;
  parameter svc_cmd_t CMD_CORRECTABLE_FAULT   = 8'h50;
  parameter svc_cmd_t CMD_UNCORRECTABLE_FAULT = 8'h51;
  parameter svc_cmd_t CMD_RELEASE_FAULT       = 8'h52;

  // State encodings.
  typedef enum logic {
    RX_IDLE         = 1'b0,
    RX_WAIT_REQ_LOW = 1'b1
  } rx_state_t;

  typedef enum logic {
    RS_IDLE = 1'b0,
    RS_HOLD = 1'b1
  } rst_seq_state_t;

endpackage

`default_nettype wire

// ==== rtl/svc_cmd_rx.sv ====
/* Service command receiver.
   Turns each four-phase req/ack exchange into a single-cycle command strobe. */

`timescale 1ns/1ns
`default_nettype none

module svc_cmd_rx import fc_svc_pkg::*; (
  input  wire logic     clk,
  input  wire logic     cptra_rst_b,
  input  wire logic     cmd_req_i,
  input  wire svc_cmd_t cmd_i,
  output logic          cmd_ack_o,
  output logic          cmd_valid_o,
  output svc_cmd_t      cmd_o
);

  rx_state_t state_q;
  logic      valid_q;
  svc_cmd_t  cmd_q;

  // Accept a request only from idle, so a held request is taken once.
  logic take_cmd;
  assign take_cmd = (state_q == RX_IDLE) && cmd_req_i;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      state_q <= RX_IDLE;
      valid_q <= 1'b0;
    end else begin
      valid_q <= take_cmd;
      case (state_q)
        RX_IDLE: begin
          if (cmd_req_i) begin
            state_q <= RX_WAIT_REQ_LOW;
          end
        end
        RX_WAIT_REQ_LOW: begin
          // The host drops its request, so the ack follows.
          if (!cmd_req_i) begin
            state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // The command is only payload and is qualified by the strobe.
  always_ff @(posedge clk) begin
    if (take_cmd) begin
      cmd_q <= cmd_i;
    end
  end

  // The ack is high for the whole time the receiver waits for the request to fall.
  assign cmd_ack_o   = (state_q == RX_WAIT_REQ_LOW);
  assign cmd_valid_o = valid_q;
  assign cmd_o       = cmd_q;

endmodule

`default_nettype wire

// ==== rtl/svc_ctrl.sv ====
/* Service command decoder.
   Holds the override flags, the clock selection handshake and the reset pulse sequencer. */

`timescale 1ns/1ns
`default_nettype none

module svc_ctrl import fc_svc_pkg::*; (
  input  wire logic     clk,
  input  wire logic     cptra_rst_b,
  input  wire logic     cmd_valid_i,
  input  wire svc_cmd_t cmd_i,
  input  wire logic     clk_switch_ack_i,
  output logic          zeroize_o,
  output logic          escalate_o,
  output clk_mhz_t      clk_mhz_o,
  output logic          clk_switch_req_o,
  output logic          sub_rst_b_o,
  output logic          fault_arm_o,
  output fault_kind_t   fault_kind_o,
  output logic          fault_release_o
);

  localparam int unsigned RST_CNT_W = $clog2(SUB_RST_CYCLES);

  logic           zeroize_q;
  logic           escalate_q;
  clk_mhz_t       clk_mhz_q;
  logic           clk_switch_req_q;
  rst_seq_state_t rs_state_q;
  logic [RST_CNT_W-1:0] rs_cnt_q;

  logic     clk_cmd_hit;
  clk_mhz_t clk_cmd_mhz;

  // --------------------------------------------------
  // Clock command lookup
  // --------------------------------------------------
  always_comb begin
    clk_cmd_hit = 1'b1;
    clk_cmd_mhz = CLK_MHZ_RST;
    case (cmd_i)
      CMD_EXT_CLK_160:  clk_cmd_mhz = clk_mhz_t'(160);
      CMD_EXT_CLK_400:  clk_cmd_mhz = clk_mhz_t'(400);
      CMD_EXT_CLK_500:  clk_cmd_mhz = clk_mhz_t'(500);
      CMD_EXT_CLK_1000: clk_cmd_mhz = clk_mhz_t'(1000);
      default:          clk_cmd_hit = 1'b0;
    endcase
  end

  // --------------------------------------------------
  // Override flags and clock selection
  // --------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      zeroize_q        <= 1'b0;
      escalate_q       <= 1'b0;
      clk_mhz_q        <= CLK_MHZ_RST;
      clk_switch_req_q <= 1'b0;
    end else begin
      // The switch request retires once the clock source acknowledges it.
      if (clk_switch_ack_i) begin
        clk_switch_req_q <= 1'b0;
      end
      if (cmd_valid_i) begin
        case (cmd_i)
          CMD_FORCE_ZEROIZATION:   zeroize_q  <= 1'b1;
          CMD_RELEASE_ZEROIZATION: zeroize_q  <= 1'b0;
          CMD_TRIGGER_ESCALATION:  escalate_q <= 1'b1;
          CMD_RELEASE_ESCALATION:  escalate_q <= 1'b0;
          default: begin
          end
        endcase
        // A new frequency wins over a pending ack and keeps the request up.
        if (clk_cmd_hit) begin
          clk_mhz_q        <= clk_cmd_mhz;
          clk_switch_req_q <= 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------
  // Sub-block reset sequencer
  // --------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      rs_state_q <= RS_IDLE;
      rs_cnt_q   <= '0;
    end else begin
      case (rs_state_q)
        RS_IDLE: begin
          if (cmd_valid_i && (cmd_i == CMD_SUB_RESET)) begin
            rs_state_q <= RS_HOLD;
            rs_cnt_q   <= '0;
          end
        end
        RS_HOLD: begin
          // Further reset commands are dropped until the window closes.
          if (rs_cnt_q == RST_CNT_W'(SUB_RST_CYCLES - 1)) begin
            rs_state_q <= RS_IDLE;
            rs_cnt_q   <= '0;
          end else begin
            rs_cnt_q <= rs_cnt_q + RST_CNT_W'(1);
          end
        end
        default: rs_state_q <= RS_IDLE;
      endcase
    end
  end

  // Fault pulses go straight out so the fuse block reacts on the strobe edge.
  assign fault_arm_o     = cmd_valid_i && ((cmd_i == CMD_CORRECTABLE_FAULT) ||
                                           (cmd_i == CMD_UNCORRECTABLE_FAULT));
  assign fault_kind_o    = (cmd_i == CMD_UNCORRECTABLE_FAULT) ? FAULT_UNCORRECTABLE
                                                               : FAULT_CORRECTABLE;
  assign fault_release_o = cmd_valid_i && (cmd_i == CMD_RELEASE_FAULT);

  assign zeroize_o        = zeroize_q;
  assign escalate_o       = escalate_q;
  assign clk_mhz_o        = clk_mhz_q;
  assign clk_switch_req_o = clk_switch_req_q;
  assign sub_rst_b_o      = (rs_state_q == RS_IDLE);

endmodule

`default_nettype wire

// ==== rtl/fuse_fault_inj.sv ====
/* Fuse word array with a fault overlay.
   Snapshots word 0 of each locked partition and returns it on reads while a fault is active. */

`timescale 1ns/1ns
`default_nettype none

module fuse_fault_inj import fc_svc_pkg::*; #(
  parameter  int unsigned NUM_PARTITIONS = 7,
  parameter  int unsigned PART_WORDS     = 4,
  localparam int unsigned NUM_WORDS      = NUM_PARTITIONS * PART_WORDS,
  localparam int unsigned ADDR_W         = $clog2(NUM_WORDS)
) (
  input  wire logic              clk,
  input  wire logic              cptra_rst_b,
  input  wire logic              fuse_we_i,
  input  wire logic [ADDR_W-1:0] fuse_addr_i,
  input  wire fuse_word_t        fuse_wdata_i,
  input  wire logic              fuse_re_i,
  input  wire logic [ADDR_W-1:0] fuse_raddr_i,
  input  wire logic              fault_arm_i,
  input  wire fault_kind_t       fault_kind_i,
  input  wire logic              fault_release_i,
  output fuse_word_t             fuse_rdata_o
);

  fuse_word_t mem_q  [NUM_WORDS];
  fuse_word_t snap_q [NUM_PARTITIONS];
  fuse_word_t flip_mask [NUM_PARTITIONS];
  fuse_word_t rd_word;
  fuse_word_t rdata_q;
  logic       fault_active_q;
  logic       arm_take;

  // A second arm while a fault is active is ignored.
  assign arm_take = fault_arm_i && !fault_active_q;

  // --------------------------------------------------
  // Array write port
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (fuse_we_i && ({1'b0, fuse_addr_i} < (ADDR_W + 1)'(NUM_WORDS))) begin
      mem_q[fuse_addr_i] <= fuse_wdata_i;
    end
  end

  // A partition is locked once its last word, the digest, is nonzero.
  always_comb begin
    for (int p = 0; p < NUM_PARTITIONS; p++) begin
      if (mem_q[p * PART_WORDS + PART_WORDS - 1] == '0) begin
        flip_mask[p] = '0;
      end else if (fault_kind_i == FAULT_UNCORRECTABLE) begin
        flip_mask[p] = '1;
      end else begin
        flip_mask[p] = fuse_word_t'(1);
      end
    end
  end

  // --------------------------------------------------
  // Fault state and snapshot
  // --------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      fault_active_q <= 1'b0;
    end else if (arm_take) begin
      fault_active_q <= 1'b1;
    end else if (fault_release_i) begin
      fault_active_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (arm_take) begin
      for (int p = 0; p < NUM_PARTITIONS; p++) begin
        snap_q[p] <= mem_q[p * PART_WORDS] ^ flip_mask[p];
      end
    end
  end

  // --------------------------------------------------
  // Read port with overlay
  // --------------------------------------------------
  always_comb begin
    rd_word = mem_q[fuse_raddr_i];
    if (fault_active_q) begin
      for (int p = 0; p < NUM_PARTITIONS; p++) begin
        if (fuse_raddr_i == ADDR_W'(p * PART_WORDS)) begin
          rd_word = snap_q[p];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fuse_re_i) begin
      rdata_q <= rd_word;
    end
  end

  assign fuse_rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== rtl/fc_svc_top.sv ====
/* Fuse and lifecycle service controller top level.
   Connects the command receiver, the decoder and the fuse fault block. */

`timescale 1ns/1ns
`default_nettype none

module fc_svc_top import fc_svc_pkg::*; #(
  parameter  int unsigned NUM_PARTITIONS = 7,
  parameter  int unsigned PART_WORDS     = 4,
  localparam int unsigned FUSE_ADDR_W    = $clog2(NUM_PARTITIONS * PART_WORDS)
) (
  input  wire logic                   clk,
  input  wire logic                   cptra_rst_b,
  // Service command link.
  input  wire logic                   cmd_req_i,
  input  wire svc_cmd_t               cmd_i,
  output logic                        cmd_ack_o,
  // Service outputs.
  output logic                        zeroize_o,
  output logic                        escalate_o,
  output clk_mhz_t                    clk_mhz_o,
  output logic                        clk_switch_req_o,
  input  wire logic                   clk_switch_ack_i,
  output logic                        sub_rst_b_o,
  // Fuse array ports.
  input  wire logic                   fuse_we_i,
  input  wire logic [FUSE_ADDR_W-1:0] fuse_addr_i,
  input  wire fuse_word_t             fuse_wdata_i,
  input  wire logic                   fuse_re_i,
  input  wire logic [FUSE_ADDR_W-1:0] fuse_raddr_i,
  output fuse_word_t                  fuse_rdata_o
);

  logic        cmd_valid;
  svc_cmd_t    cmd;
  logic        fault_arm;
  fault_kind_t fault_kind;
  logic        fault_release;

  svc_cmd_rx svc_cmd_rx_i (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .cmd_req_i   (cmd_req_i),
    .cmd_i       (cmd_i),
    .cmd_ack_o   (cmd_ack_o),
    .cmd_valid_o (cmd_valid),
    .cmd_o       (cmd)
  );

  svc_ctrl svc_ctrl_i (
    .clk              (clk),
    .cptra_rst_b      (cptra_rst_b),
    .cmd_valid_i      (cmd_valid),
    .cmd_i            (cmd),
    .clk_switch_ack_i (clk_switch_ack_i),
    .zeroize_o        (zeroize_o),
    .escalate_o       (escalate_o),
    .clk_mhz_o        (clk_mhz_o),
    .clk_switch_req_o (clk_switch_req_o),
    .sub_rst_b_o      (sub_rst_b_o),
    .fault_arm_o      (fault_arm),
    .fault_kind_o     (fault_kind),
    .fault_release_o  (fault_release)
  );

  fuse_fault_inj #(
    .NUM_PARTITIONS (NUM_PARTITIONS),
    .PART_WORDS     (PART_WORDS)
  ) fuse_fault_inj_i (
    .clk             (clk),
    .cptra_rst_b     (cptra_rst_b),
    .fuse_we_i       (fuse_we_i),
    .fuse_addr_i     (fuse_addr_i),
    .fuse_wdata_i    (fuse_wdata_i),
    .fuse_re_i       (fuse_re_i),
    .fuse_raddr_i    (fuse_raddr_i),
    .fault_arm_i     (fault_arm),
    .fault_kind_i    (fault_kind),
    .fault_release_i (fault_release),
    .fuse_rdata_o    (fuse_rdata_o)
  );

endmodule

`default_nettype wire

// ==== bench/fc_svc_assertions.sv ====
/* Concurrent checks on the command handshake, the clock switch request
   and the length of the sub-block reset window. */

`timescale 1ns/1ns
`default_nettype none

module fc_svc_assertions import fc_svc_pkg::*; (
  input wire logic clk,
  input wire logic cptra_rst_b,
  input wire logic req_i,
  input wire logic ack_i,
  input wire logic sw_req_i,
  input wire logic sw_ack_i,
  input wire logic sub_rst_b_i
);

  // Number of consecutive samples with the sub-block reset asserted.
  int unsigned low_cnt;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      low_cnt <= 0;
    end else if (!sub_rst_b_i) begin
      low_cnt <= low_cnt + 1;
    end else begin
      low_cnt <= 0;
    end
  end

  ack_rise_needs_req: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    $rose(ack_i) |-> $past(req_i))
    else $error("cmd ack rose without a request");

  req_gets_ack: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    (req_i && !ack_i) |=> ack_i)
    else $error("cmd request was not acknowledged on the next cycle");

  sw_req_holds: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    (sw_req_i && !sw_ack_i) |=> sw_req_i)
    else $error("clock switch request dropped before its ack");

  sub_rst_window: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    low_cnt <= SUB_RST_CYCLES)
    else $error("sub-block reset held longer than the window");

endmodule

// The receiver instance checks the command link, the decoder the clock and reset outputs.
bind svc_cmd_rx fc_svc_assertions rx_assertions_i (
  .clk         (clk),
  .cptra_rst_b (cptra_rst_b),
  .req_i       (cmd_req_i),
  .ack_i       (cmd_ack_o),
  .sw_req_i    (1'b0),
  .sw_ack_i    (1'b0),
  .sub_rst_b_i (1'b1)
);

bind svc_ctrl fc_svc_assertions ctrl_assertions_i (
  .clk         (clk),
  .cptra_rst_b (cptra_rst_b),
  .req_i       (1'b0),
  .ack_i       (1'b0),
  .sw_req_i    (clk_switch_req_o),
  .sw_ack_i    (clk_switch_ack_i),
  .sub_rst_b_i (sub_rst_b_o)
);

`default_nettype wire

// ==== bench/fc_svc_tb.sv ====
/* Directed testbench for the fuse and lifecycle service controller.
   Drives the command link and the fuse ports and checks every response. */

`timescale 1ns/1ns
`default_nettype none

module fc_svc_tb
  import fc_svc_pkg::*;
();

  localparam int unsigned NUM_PARTITIONS = 7;
  localparam int unsigned PART_WORDS     = 4;
  localparam int unsigned NUM_WORDS      = NUM_PARTITIONS * PART_WORDS;
  localparam int unsigned FUSE_ADDR_W    = $clog2(NUM_WORDS);
  localparam int          WAIT_LIMIT     = 40;

  typedef logic [FUSE_ADDR_W-1:0] fuse_addr_t;

  logic       clk = 1'b0;
  logic       cptra_rst_b;
  logic       cmd_req_i;
  svc_cmd_t   cmd_i;
  logic       cmd_ack_o;
  logic       zeroize_o;
  logic       escalate_o;
  clk_mhz_t   clk_mhz_o;
  logic       clk_switch_req_o;
  logic       clk_switch_ack_i;
  logic       sub_rst_b_o;
  logic       fuse_we_i;
  fuse_addr_t fuse_addr_i;
  fuse_word_t fuse_wdata_i;
  logic       fuse_re_i;
  fuse_addr_t fuse_raddr_i;
  fuse_word_t fuse_rdata_o;

  integer     seed        = 32'h667e7c06;
  int         err_cnt     = 0;
  int         timeout_cnt = 0;
  int         check_cnt   = 0;
  fuse_word_t exp_mem [NUM_WORDS];

  // Width and number of the completed low pulses on sub_rst_b_o.
  int low_run   = 0;
  int pulse_len = 0;
  int pulse_cnt = 0;

  always #20 clk = ~clk;

  fc_svc_top #(
    .NUM_PARTITIONS (NUM_PARTITIONS),
    .PART_WORDS     (PART_WORDS)
  ) fc_svc_top_i (
    .clk              (clk),
    .cptra_rst_b      (cptra_rst_b),
    .cmd_req_i        (cmd_req_i),
    .cmd_i            (cmd_i),
    .cmd_ack_o        (cmd_ack_o),
    .zeroize_o        (zeroize_o),
    .escalate_o       (escalate_o),
    .clk_mhz_o        (clk_mhz_o),
    .clk_switch_req_o (clk_switch_req_o),
    .clk_switch_ack_i (clk_switch_ack_i),
    .sub_rst_b_o      (sub_rst_b_o),
    .fuse_we_i        (fuse_we_i),
    .fuse_addr_i      (fuse_addr_i),
    .fuse_wdata_i     (fuse_wdata_i),
    .fuse_re_i        (fuse_re_i),
    .fuse_raddr_i     (fuse_raddr_i),
    .fuse_rdata_o     (fuse_rdata_o)
  );

  always @(negedge clk) begin
    if (sub_rst_b_o === 1'b0) begin
      low_run <= low_run + 1;
    end else if (low_run != 0) begin
      pulse_len <= low_run;
      pulse_cnt <= pulse_cnt + 1;
      low_run   <= 0;
    end
  end

  // --------------------------------------------------
  // Reporting and compare tasks
  // --------------------------------------------------
  task automatic end_run();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(string what);
    $display("Timed out waiting for %s", what);
    timeout_cnt++;
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    check_cnt++;
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_mhz(string name, clk_mhz_t got, clk_mhz_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_word(string name, fuse_word_t got, fuse_word_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    check_cnt++;
    if (got != exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  // --------------------------------------------------
  // Bus tasks enter and leave on a falling edge
  // --------------------------------------------------
  task automatic wait_ack(logic level);
    int cnt;
    cnt = 0;
    while (cmd_ack_o !== level) begin
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        report_timeout("cmd_ack_o to change level");
        break;
      end
    end
  endtask

  task automatic send_cmd(svc_cmd_t code);
    cmd_i     = code;
    cmd_req_i = 1'b1;
    wait_ack(1'b1);
    // The ack has to stay up for as long as the request does.
    @(negedge clk);
    check_bit("cmd_ack_o", cmd_ack_o, 1'b1);
    cmd_req_i = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic ack_clk_switch();
    int cnt;
    cnt = 0;
    clk_switch_ack_i = 1'b1;
    while (clk_switch_req_o !== 1'b0) begin
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        report_timeout("clk_switch_req_o to fall");
        break;
      end
    end
    clk_switch_ack_i = 1'b0;
  endtask

  task automatic wait_sub_rst_high();
    int cnt;
    cnt = 0;
    while (sub_rst_b_o !== 1'b1) begin
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        report_timeout("sub_rst_b_o to be released");
        break;
      end
    end
  endtask

  task automatic fuse_write(fuse_addr_t addr, fuse_word_t data);
    fuse_we_i    = 1'b1;
    fuse_addr_i  = addr;
    fuse_wdata_i = data;
    @(negedge clk);
    fuse_we_i = 1'b0;
  endtask

  task automatic fuse_read(fuse_addr_t addr, output fuse_word_t data);
    fuse_re_i    = 1'b1;
    fuse_raddr_i = addr;
    @(negedge clk);
    fuse_re_i = 1'b0;
    data      = fuse_rdata_o;
  endtask

  task automatic load_fuses();
    fuse_word_t data;
    for (int a = 0; a < NUM_WORDS; a++) begin
      data = fuse_word_t'($random(seed));
      if (a % PART_WORDS == PART_WORDS - 1) begin
        // Partitions 1 and 4 keep a blank digest and stay unlocked.
        if ((a / PART_WORDS) % 3 == 1) begin
          data = '0;
        end else begin
          data = data | 16'h0001;
        end
      end
      exp_mem[a] = data;
      fuse_write(fuse_addr_t'(a), data);
    end
  endtask

  // Word 0 of a locked partition reads through the fault mask, all else as loaded.
  task automatic check_array(logic fault_on, fault_kind_t kind);
    fuse_word_t got;
    fuse_word_t exp;
    fuse_word_t mask;
    int         digest_addr;
    mask = (kind == FAULT_UNCORRECTABLE) ? 16'hffff : 16'h0001;
    for (int a = 0; a < NUM_WORDS; a++) begin
      digest_addr = (a / PART_WORDS) * PART_WORDS + PART_WORDS - 1;
      exp = exp_mem[a];
      if (fault_on && (a % PART_WORDS == 0) && (exp_mem[digest_addr] != '0)) begin
        exp = exp ^ mask;
      end
      fuse_read(fuse_addr_t'(a), got);
      check_word($sformatf("fuse_rdata_o[%0d]", a), got, exp);
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic check_idle_outputs(logic zeroize, logic escalate);
    check_bit("cmd_ack_o", cmd_ack_o, 1'b0);
    check_bit("zeroize_o", zeroize_o, zeroize);
    check_bit("escalate_o", escalate_o, escalate);
    check_bit("clk_switch_req_o", clk_switch_req_o, 1'b0);
    check_bit("sub_rst_b_o", sub_rst_b_o, 1'b1);
    check_mhz("clk_mhz_o", clk_mhz_o, 11'd1000);
  endtask

  task automatic test_reset_and_handshake();
    check_idle_outputs(1'b0, 1'b0);
    send_cmd(8'h7f);
    check_idle_outputs(1'b0, 1'b0);
  endtask

  task automatic test_overrides();
    send_cmd(CMD_FORCE_ZEROIZATION);
    check_idle_outputs(1'b1, 1'b0);
    send_cmd(CMD_TRIGGER_ESCALATION);
    check_idle_outputs(1'b1, 1'b1);
    send_cmd(8'ha5);
    check_idle_outputs(1'b1, 1'b1);
    send_cmd(CMD_RELEASE_ZEROIZATION);
    check_idle_outputs(1'b0, 1'b1);
    send_cmd(CMD_RELEASE_ESCALATION);
    check_idle_outputs(1'b0, 1'b0);
  endtask

  task automatic test_clock_select();
    svc_cmd_t cmds [4];
    clk_mhz_t mhz  [4];
    cmds[0] = CMD_EXT_CLK_400;
    cmds[1] = CMD_EXT_CLK_1000;
    cmds[2] = CMD_EXT_CLK_160;
    cmds[3] = CMD_EXT_CLK_500;
    mhz[0]  = 11'd400;
    mhz[1]  = 11'd1000;
    mhz[2]  = 11'd160;
    mhz[3]  = 11'd500;
    for (int i = 0; i < 4; i++) begin
      send_cmd(cmds[i]);
      check_mhz("clk_mhz_o", clk_mhz_o, mhz[i]);
      check_bit("clk_switch_req_o", clk_switch_req_o, 1'b1);
      repeat (3) @(negedge clk);
      check_bit("clk_switch_req_o", clk_switch_req_o, 1'b1);
      ack_clk_switch();
    end
    // A selection while the switch is pending updates the frequency only.
    send_cmd(CMD_EXT_CLK_1000);
    send_cmd(CMD_EXT_CLK_160);
    check_mhz("clk_mhz_o", clk_mhz_o, 11'd160);
    check_bit("clk_switch_req_o", clk_switch_req_o, 1'b1);
    ack_clk_switch();
  endtask

  task automatic test_sub_reset();
    int start_cnt;
    start_cnt = pulse_cnt;
    send_cmd(CMD_SUB_RESET);
    check_bit("sub_rst_b_o", sub_rst_b_o, 1'b0);
    send_cmd(CMD_SUB_RESET);
    check_bit("sub_rst_b_o", sub_rst_b_o, 1'b0);
    wait_sub_rst_high();
    @(negedge clk);
    check_count("sub_rst_b_o low cycles", pulse_len, SUB_RST_CYCLES);
    check_count("sub_rst_b_o pulses", pulse_cnt - start_cnt, 1);
  endtask

  task automatic test_faults();
    load_fuses();
    check_array(1'b0, FAULT_CORRECTABLE);
    send_cmd(CMD_CORRECTABLE_FAULT);
    check_array(1'b1, FAULT_CORRECTABLE);
    send_cmd(CMD_UNCORRECTABLE_FAULT);
    check_array(1'b1, FAULT_CORRECTABLE);
    send_cmd(CMD_RELEASE_FAULT);
    check_array(1'b0, FAULT_CORRECTABLE);
    send_cmd(CMD_UNCORRECTABLE_FAULT);
    check_array(1'b1, FAULT_UNCORRECTABLE);
    send_cmd(CMD_RELEASE_FAULT);
    check_array(1'b0, FAULT_CORRECTABLE);
  endtask

  initial begin
    cptra_rst_b      = 1'b0;
    cmd_req_i        = 1'b0;
    cmd_i            = '0;
    clk_switch_ack_i = 1'b0;
    fuse_we_i        = 1'b0;
    fuse_addr_i      = '0;
    fuse_wdata_i     = '0;
    fuse_re_i        = 1'b0;
    fuse_raddr_i     = '0;
    repeat (2) @(negedge clk);
    cptra_rst_b = 1'b1;
    @(negedge clk);
    test_reset_and_handshake();
    test_overrides();
    test_clock_select();
    test_sub_reset();
    test_faults();
    end_run();
  end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/fc_svc_pkg.sv
rtl/svc_cmd_rx.sv
rtl/svc_ctrl.sv
rtl/fuse_fault_inj.sv
rtl/fc_svc_top.sv
bench/fc_svc_assertions.sv
bench/fc_svc_tb.sv

// ==== Makefile ====
# Verilator build and run of the fuse and lifecycle service controller testbench.

SIM := obj_dir/fc_svc_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f all.f --top-module fc_svc_tb -Mdir obj_dir -o fc_svc_sim

run: compile
	./$(SIM) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
